// File: bpc_defs.svh
// width, image size, table depth and region cap macros for the bad pixel checker
`ifndef BPC_DEFS_SVH
`define BPC_DEFS_SVH

// ====================
// coordinate widths
// ====================
`define BPC_X_BITS        10   // pixel x
`define BPC_Y_BITS        10   // line y

// ====================
// coordinate table
// ====================
`define BPC_POINT_DEPTH   128  // table entries
`define BPC_POINT_BITS    7    // table address

// image geometry
`define BPC_IMAGE_WIDTH   640
`define BPC_IMAGE_HEIGHT  512

// line cache sizing
`define BPC_MAX_REGIONS   16   // regions kept per line
`define BPC_REGION_HALF   2    // 5x5 neighbourhood, +-2
// region count must reach BPC_MAX_REGIONS itself, hence the +1
`define BPC_COUNT_BITS    ($clog2(`BPC_MAX_REGIONS + 1))

`endif

// File: bpc_pkg.sv
// coordinate, region, table write, pixel and FSM state types
`include "bpc_defs.svh"

package bpc_pkg;

    // one bad point as stored in the table
    typedef struct packed {
        logic [`BPC_Y_BITS-1:0] y;
        logic [`BPC_X_BITS-1:0] x;
    } coord_t;

    // cached x interval for one line, inclusive on both ends
    typedef struct packed {
        logic [`BPC_X_BITS-1:0] x_end;
        logic [`BPC_X_BITS-1:0] x_start;
    } region_t;

    // config side table write
    typedef struct packed {
        logic                       wen;
        logic [`BPC_POINT_BITS-1:0] addr;
        coord_t                     data;
    } cfg_wr_t;

    // position of the pixel on the stream
    typedef struct packed {
        logic [`BPC_Y_BITS-1:0] y;
        logic [`BPC_X_BITS-1:0] x;
    } pixel_t;

    typedef enum logic [1:0] {IDLE, START_BUILD, BUILD, SWAP_RUN} fsm_state_t;

endpackage

// File: coord_table.sv
// coordinate table, one write port from config and one registered read port
`timescale 1ns/1ps
`include "bpc_defs.svh"

module coord_table (
    input  logic                       S_AXI_ACLK,
    input  bpc_pkg::cfg_wr_t           cfg_wr,    // config write
    input  logic [`BPC_POINT_BITS-1:0] rd_addr,   // from scan counter
    output bpc_pkg::coord_t            rd_data    // valid one cycle after rd_addr
);

    // ====================
    // storage
    // ====================
    bpc_pkg::coord_t mem [`BPC_POINT_DEPTH];

    // write side
    always_ff @(posedge S_AXI_ACLK) begin
        if (cfg_wr.wen) begin
            mem[cfg_wr.addr] <= cfg_wr.data;
        end
    end

    // read side, block RAM style output register
    always_ff @(posedge S_AXI_ACLK) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: scan_counter.sv
// table scan counter with four-phase req/ack toward the line cache FSM
`timescale 1ns/1ps
`include "bpc_defs.svh"

module scan_counter (
    input  logic                       S_AXI_ACLK,
    input  logic                       rst_n,
    input  logic [`BPC_POINT_BITS:0]   point_num,  // valid entries, 0..depth
    input  logic                       scan_req,
    output logic                       scan_ack,
    output logic [`BPC_POINT_BITS-1:0] rd_addr,
    output logic                       rd_valid    // rd_data valid this cycle
);

    logic                     active;   // scan in progress
    logic                     phase;    // 0 address, 1 data
    logic [`BPC_POINT_BITS:0] cnt;      // entry being read

    assign rd_addr = cnt[`BPC_POINT_BITS-1:0];

    always_ff @(posedge S_AXI_ACLK) begin
        if (!rst_n) begin
            active   <= 1'b0;
            phase    <= 1'b0;
            cnt      <= '0;
            scan_ack <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= active && !phase;  // data lands one cycle after address
            if (scan_ack) begin
                if (!scan_req) scan_ack <= 1'b0;  // release after req drops
            end else if (!active) begin
                if (scan_req) begin
                    if (point_num == '0) scan_ack <= 1'b1;  // empty table
                    else begin
                        active <= 1'b1;
                        cnt    <= '0;
                        phase  <= 1'b0;
                    end
                end
            end else if (!phase) begin
                phase <= 1'b1;                             // address out, wait data
            end else if (cnt + 1'b1 == point_num) begin
                active   <= 1'b0;                          // last entry consumed
                scan_ack <= 1'b1;
            end else begin
                cnt   <= cnt + 1'b1;
                phase <= 1'b0;
            end
        end
    end

endmodule

// File: line_cache_fsm.sv
// line cache FSM: frame start, next line prefetch, table scan handshake and swap
`timescale 1ns/1ps
`include "bpc_defs.svh"

module line_cache_fsm (
    input  logic                   S_AXI_ACLK,
    input  logic                   rst_n,
    input  logic                   frame_start,  // level, rising edge used
    input  bpc_pkg::pixel_t        pixel,
    output logic                   scan_req,
    input  logic                   scan_ack,
    output logic [`BPC_Y_BITS-1:0] build_y,      // line being built
    output logic                   clear_next,   // empty next buffer
    output logic                   swap,         // next -> current
    output logic                   busy,         // next line not swapped in yet
    output logic                   cache_valid   // current buffer usable
);

    bpc_pkg::fsm_state_t    state;
    logic                   fs_d;      // frame_start delayed
    logic                   restart;   // frame edge seen mid build
    logic [`BPC_Y_BITS-1:0] cur_y;     // line held in current buffer
    logic [`BPC_Y_BITS:0]   next_y;    // one extra bit, y+1 can pass the height
    logic                   fs_edge;
    logic                   line_end;

    assign fs_edge    = frame_start && !fs_d;
    assign next_y     = {1'b0, pixel.y} + 1'b1;
    // last pixel of a line, not the last line, not already prefetched
    assign line_end   = (pixel.x == `BPC_IMAGE_WIDTH - 1) &&
                        (next_y < `BPC_IMAGE_HEIGHT) &&
                        (next_y[`BPC_Y_BITS-1:0] != cur_y);
    assign clear_next = (state == bpc_pkg::START_BUILD);  // single cycle state

    always_ff @(posedge S_AXI_ACLK) begin
        if (!rst_n) begin
            state       <= bpc_pkg::IDLE;
            fs_d        <= 1'b0;
            restart     <= 1'b0;
            scan_req    <= 1'b0;
            build_y     <= '0;
            cur_y       <= '0;
            swap        <= 1'b0;
            busy        <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            fs_d <= frame_start;
            swap <= 1'b0;  // pulse
            case (state)
                bpc_pkg::IDLE: begin
                    if (fs_edge) begin
                        build_y <= '0;
                        busy    <= 1'b1;
                        state   <= bpc_pkg::START_BUILD;
                    end
                end
                bpc_pkg::START_BUILD: begin
                    scan_req <= 1'b1;
                    if (fs_edge) restart <= 1'b1;
                    state <= bpc_pkg::BUILD;
                end
                bpc_pkg::BUILD: begin
                    if (fs_edge) restart <= 1'b1;  // finish handshake first
                    if (scan_req && scan_ack) begin
                        scan_req <= 1'b0;
                    end else if (!scan_req && !scan_ack) begin
                        if (restart || fs_edge) begin
                            restart <= 1'b0;        // new frame, rebuild line 0
                            build_y <= '0;
                            state   <= bpc_pkg::START_BUILD;
                        end else begin
                            swap  <= 1'b1;
                            cur_y <= build_y;
                            state <= bpc_pkg::SWAP_RUN;
                        end
                    end
                end
                bpc_pkg::SWAP_RUN: begin
                    if (swap) begin
                        busy        <= 1'b0;  // falls the cycle after swap
                        cache_valid <= 1'b1;
                    end
                    if (fs_edge) begin
                        build_y <= '0;
                        busy    <= 1'b1;
                        state   <= bpc_pkg::START_BUILD;
                    end else if (line_end) begin
                        build_y <= next_y[`BPC_Y_BITS-1:0];  // prefetch y+1
                        busy    <= 1'b1;
                        state   <= bpc_pkg::START_BUILD;
                    end
                end
                default: state <= bpc_pkg::IDLE;
            endcase
            if (fs_edge) cache_valid <= 1'b0;  // old frame cache is stale
        end
    end

endmodule

// File: region_builder.sv
// line cache builder: 5x5 expansion of read points, next buffer fill and swap
`timescale 1ns/1ps
`include "bpc_defs.svh"

module region_builder (
    input  logic                                         S_AXI_ACLK,
    input  logic                                         rst_n,
    input  logic [`BPC_Y_BITS-1:0]                       build_y,
    input  logic                                         clear_next,
    input  logic                                         rd_valid,
    input  bpc_pkg::coord_t                              rd_data,
    input  logic                                         swap,
    output bpc_pkg::region_t [`BPC_MAX_REGIONS-1:0]      cur_regions,
    output logic [`BPC_COUNT_BITS-1:0]                   cur_count
);

    // ====================
    // next line buffer
    // ====================
    bpc_pkg::region_t [`BPC_MAX_REGIONS-1:0] next_regions;
    logic [`BPC_COUNT_BITS-1:0]              next_count;

    // ====================
    // 5x5 expansion
    // ====================
    logic [`BPC_Y_BITS-1:0] y_lo;     // clamped at 0
    logic [`BPC_Y_BITS:0]   y_hi;     // extra bit, no wrap past the top
    logic [`BPC_X_BITS-1:0] x_lo;
    logic [`BPC_X_BITS-1:0] x_hi;
    logic                   hit;      // point touches build_y
    logic                   room;     // cap not reached

    assign y_lo = (rd_data.y >= `BPC_REGION_HALF) ? rd_data.y - `BPC_REGION_HALF : '0;
    assign y_hi = {1'b0, rd_data.y} + `BPC_REGION_HALF;
    assign x_lo = (rd_data.x >= `BPC_REGION_HALF) ? rd_data.x - `BPC_REGION_HALF : '0;
    assign x_hi = rd_data.x + `BPC_REGION_HALF;  // x stays inside the image

    assign hit  = (build_y >= y_lo) && ({1'b0, build_y} <= y_hi);
    assign room = (next_count < `BPC_MAX_REGIONS);

    // control: counts only
    always_ff @(posedge S_AXI_ACLK) begin
        if (!rst_n) begin
            next_count <= '0;
            cur_count  <= '0;
        end else begin
            if (clear_next) begin
                next_count <= '0;
            end else if (rd_valid && hit && room) begin
                next_count <= next_count + 1'b1;
            end
            if (swap) cur_count <= next_count;
        end
    end

    // payload: region slots, only the first count entries matter
    always_ff @(posedge S_AXI_ACLK) begin
        if (!clear_next && rd_valid && hit && room) begin
            next_regions[next_count] <= '{x_end: x_hi, x_start: x_lo};
        end
        if (swap) begin
            cur_regions <= next_regions;  // whole buffer copied in one cycle
        end
    end

    // first 16 in address order win, later hits on the same line are dropped
    // swap and rd_valid never overlap, FSM only swaps after ack

endmodule

// File: region_matcher.sv
// parallel x match of the current pixel against the current line cache
`timescale 1ns/1ps
`include "bpc_defs.svh"

module region_matcher (
    input  bpc_pkg::pixel_t                          pixel,
    input  bpc_pkg::region_t [`BPC_MAX_REGIONS-1:0]  cur_regions,
    input  logic [`BPC_COUNT_BITS-1:0]               cur_count,
    input  logic                                     cache_valid,
    output logic                                     bad_pixel_match
);

    // ====================
    // per region compare
    // ====================
    // y is already folded into the cache, only x compared here
    logic [`BPC_MAX_REGIONS-1:0] hits;

    genvar i;
    generate
        for (i = 0; i < `BPC_MAX_REGIONS; i = i + 1) begin : gen_match
            logic in_use;   // slot below cur_count
            logic in_x;     // x inside [start, end]

            assign in_use  = (i < cur_count);
            assign in_x    = (pixel.x >= cur_regions[i].x_start) &&
                             (pixel.x <= cur_regions[i].x_end);
            assign hits[i] = in_use && in_x;
        end
    endgenerate

    // ====================
    // result
    // ====================
    // same cycle as pixel, nothing flagged before first swap of a frame
    assign bad_pixel_match = cache_valid && (|hits);

endmodule

// File: bad_pixel_checker.sv
// bad pixel checker top: table, scan counter, cache FSM, builder and matcher
`timescale 1ns/1ps
`include "bpc_defs.svh"

module bad_pixel_checker (
    input  logic                     S_AXI_ACLK,
    input  logic                     rst_n,
    input  bpc_pkg::cfg_wr_t         cfg_wr,
    input  logic [`BPC_POINT_BITS:0] point_num,
    input  logic                     frame_start,
    input  bpc_pkg::pixel_t          pixel,
    output logic                     bad_pixel_match,
    output logic                     busy
);

    // table read path
    logic [`BPC_POINT_BITS-1:0]              rd_addr;
    logic                                    rd_valid;
    bpc_pkg::coord_t                         rd_data;
    // handshake and cache control
    logic                                    scan_req;
    logic                                    scan_ack;
    logic [`BPC_Y_BITS-1:0]                  build_y;
    logic                                    clear_next;
    logic                                    swap;
    logic                                    cache_valid;
    // current line cache
    bpc_pkg::region_t [`BPC_MAX_REGIONS-1:0] cur_regions;
    logic [`BPC_COUNT_BITS-1:0]              cur_count;

    coord_table u_coord_table (
        .S_AXI_ACLK(S_AXI_ACLK), .cfg_wr(cfg_wr), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    scan_counter u_scan_counter (
        .S_AXI_ACLK(S_AXI_ACLK), .rst_n(rst_n), .point_num(point_num),
        .scan_req(scan_req), .scan_ack(scan_ack), .rd_addr(rd_addr), .rd_valid(rd_valid)
    );

    line_cache_fsm u_line_cache_fsm (
        .S_AXI_ACLK(S_AXI_ACLK), .rst_n(rst_n), .frame_start(frame_start), .pixel(pixel),
        .scan_req(scan_req), .scan_ack(scan_ack), .build_y(build_y),
        .clear_next(clear_next), .swap(swap), .busy(busy), .cache_valid(cache_valid)
    );

    region_builder u_region_builder (
        .S_AXI_ACLK(S_AXI_ACLK), .rst_n(rst_n), .build_y(build_y),
        .clear_next(clear_next), .rd_valid(rd_valid), .rd_data(rd_data), .swap(swap),
        .cur_regions(cur_regions), .cur_count(cur_count)
    );

    region_matcher u_region_matcher (
        .pixel(pixel), .cur_regions(cur_regions), .cur_count(cur_count),
        .cache_valid(cache_valid), .bad_pixel_match(bad_pixel_match)
    );

endmodule

// File: tb_bad_pixel_checker.sv
// testbench for the bad pixel checker: clock, reset, table writes, line streaming, model checks
`timescale 1ns/1ps
`include "bpc_defs.svh"

module tb_bad_pixel_checker;

    localparam int BUSY_TIMEOUT = 2 * `BPC_POINT_DEPTH + 16;  // longest build plus margin

    logic                     S_AXI_ACLK;
    logic                     rst_n;
    bpc_pkg::cfg_wr_t         cfg_wr;
    logic [`BPC_POINT_BITS:0] point_num;
    logic                     frame_start;
    bpc_pkg::pixel_t          pixel;
    logic                     bad_pixel_match;
    logic                     busy;

    // table copy for the model
    int     tab_x [`BPC_POINT_DEPTH];
    int     tab_y [`BPC_POINT_DEPTH];
    int     num_points;
    int     match_errors;
    int     timeout_errors;
    integer seed;
    int     k;
    int     line;

    bad_pixel_checker UUT (
        .S_AXI_ACLK(S_AXI_ACLK), .rst_n(rst_n), .cfg_wr(cfg_wr), .point_num(point_num),
        .frame_start(frame_start), .pixel(pixel), .bad_pixel_match(bad_pixel_match),
        .busy(busy)
    );

    always #4 S_AXI_ACLK = ~S_AXI_ACLK;  // 8 ns period

    // ====================
    // reference model
    // ====================
    // 5x5 window per point, only the first 16 points touching the line count
    function automatic logic model_match(input int px, input int py);
        int  i;
        int  found;
        logic flag;
        flag  = 1'b0;
        found = 0;
        for (i = 0; i < num_points; i++) begin
            if (py >= tab_y[i] - `BPC_REGION_HALF && py <= tab_y[i] + `BPC_REGION_HALF) begin
                if (found < `BPC_MAX_REGIONS && px >= tab_x[i] - `BPC_REGION_HALF &&
                    px <= tab_x[i] + `BPC_REGION_HALF) flag = 1'b1;
                found++;  // capped slot used even when x misses
            end
        end
        return flag;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            match_errors++;
            $display("MISMATCH %s pixel=(x %h, y %h) got %h expected %h",
                     name, pixel.x, pixel.y, got, exp);
        end
    endtask

    task automatic wait_busy_low(input string what);
        int cycles;
        cycles = 0;
        while (busy !== 1'b0 && cycles < BUSY_TIMEOUT) begin
            @(negedge S_AXI_ACLK);
            cycles++;
        end
        if (busy !== 1'b0) begin
            timeout_errors++;
            $display("timeout: busy still high %0d cycles after %s", BUSY_TIMEOUT, what);
        end
    endtask

    task automatic write_point(input int addr, input int x, input int y);
        @(negedge S_AXI_ACLK);
        cfg_wr.wen    = 1'b1;
        cfg_wr.addr   = addr[`BPC_POINT_BITS-1:0];
        cfg_wr.data.x = x[`BPC_X_BITS-1:0];
        cfg_wr.data.y = y[`BPC_Y_BITS-1:0];
        tab_x[addr]   = x;
        tab_y[addr]   = y;
        @(negedge S_AXI_ACLK);
        cfg_wr.wen    = 1'b0;
    endtask

    task automatic set_count(input int n);
        @(negedge S_AXI_ACLK);
        point_num  = n[`BPC_POINT_BITS:0];
        num_points = n;
    endtask

    // pixel parked off the line end so no prefetch fires
    task automatic start_frame();
        @(negedge S_AXI_ACLK);
        pixel       = '0;
        frame_start = 1'b1;
        @(negedge S_AXI_ACLK);
        frame_start = 1'b0;
        wait_busy_low("frame start");
    endtask

    // whole line, then wait for the prefetched line to swap in
    task automatic stream_line(input int y);
        int x;
        for (x = 0; x < `BPC_IMAGE_WIDTH; x++) begin
            @(negedge S_AXI_ACLK);
            pixel.x = x[`BPC_X_BITS-1:0];
            pixel.y = y[`BPC_Y_BITS-1:0];
            #1;  // combinational match settled
            check_bit("bad_pixel_match", bad_pixel_match, model_match(x, y));
        end
        @(negedge S_AXI_ACLK);
        pixel.x = '0;
        wait_busy_low($sformatf("end of line %0d", y));
    endtask

    initial begin
        S_AXI_ACLK     = 1'b0;
        rst_n          = 1'b0;
        cfg_wr         = '0;
        point_num      = '0;
        frame_start    = 1'b0;
        pixel          = '0;
        num_points     = 0;
        match_errors   = 0;
        timeout_errors = 0;
        seed           = 64;
        repeat (2) @(posedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        rst_n = 1'b1;

        // ====================
        // 1: idle after reset
        // ====================
        for (k = 0; k < 20; k++) begin
            @(negedge S_AXI_ACLK);
            pixel.x = {$random(seed)} % 1024;
            pixel.y = {$random(seed)} % 1024;
            #1;
            check_bit("bad_pixel_match", bad_pixel_match, 1'b0);
            check_bit("busy", busy, 1'b0);
        end

        // 2: clamped lower edges
        write_point(0, 0, 0);
        write_point(1, 1, 1);
        write_point(2, 100, 0);
        write_point(3, 200, 1);
        set_count(4);
        start_frame();
        stream_line(0);
        stream_line(1);

        // ====================
        // 3: random points, prefetch and swap over six lines
        // ====================
        for (k = 0; k < 20; k++) write_point(k, {$random(seed)} % 640, {$random(seed)} % 8);
        set_count(20);
        start_frame();
        for (line = 0; line < 6; line++) stream_line(line);

        // 4: twenty points on one line, cap at 16 regions
        for (k = 0; k < 20; k++) write_point(k, 8 + 30 * k, 0);
        set_count(20);
        start_frame();
        for (line = 0; line < 3; line++) stream_line(line);

        // ====================
        // 5: rewrite, entries at and above point_num ignored
        // ====================
        for (k = 0; k < 12; k++) begin
            if (k < 6) write_point(k, {$random(seed)} % 640, {$random(seed)} % 4);
            else write_point(k, 100 * (k - 6) + 50, 0);  // would hit line 0 if counted
        end
        set_count(6);
        start_frame();
        stream_line(0);

        $display("errors: mismatch=%0d timeout=%0d", match_errors, timeout_errors);
        if (match_errors == 0 && timeout_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: bad_pixel_checker.f
+incdir+.
bpc_pkg.sv
coord_table.sv
scan_counter.sv
line_cache_fsm.sv
region_builder.sv
region_matcher.sv
bad_pixel_checker.sv
tb_bad_pixel_checker.sv

// File: run_sim.sh
#!/bin/sh
# build and run the bad pixel checker testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_bad_pixel_checker -f bad_pixel_checker.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
exit 0
